//--- Makefile
SRCS := $(filter-out +%,$(shell cat audio_subsystem.f)) logic/audio_macros.svh

.PHONY: all run clean

all: run

obj_dir/Vaudio_subsystem_tb: audio_subsystem.f $(SRCS)
	verilator --binary -j 0 --assert -Wno-fatal --top-module audio_subsystem_tb \
		-f audio_subsystem.f

run: obj_dir/Vaudio_subsystem_tb
	@out="$$(./obj_dir/Vaudio_subsystem_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- audio_subsystem.f
+incdir+logic
logic/audio_pkg.sv
logic/vram.sv
logic/vram_arbiter.sv
logic/audio_mixer.sv
logic/audio_dac.sv
logic/audio_subsystem.sv
bench/audio_subsystem_tb.sv

//--- bench/audio_subsystem_tb.sv
/*
 * Audio subsystem testbench
 * Directed tests for host VRAM access, channel volume, mixing with clamping
 * and reload timing, judged by pulse counts on the two PDM outputs.
 */

`include "audio_macros.svh"

module audio_subsystem_tb
    import audio_pkg::*;
();

    localparam int NCH          = `AUDIO_NCHAN;
    localparam int ACK_LIMIT    = 16;                   // clocks a host access may wait
    localparam int ACCESS_CYC   = ACK_LIMIT + 2;
    localparam int SETTLE_CYC   = 600;                  // several buffer loops at period 30+
    localparam int MEASURE_CYC  = 256;
    localparam int RELOAD_LIMIT = 400;

    // worst-case length of each test, in clocks
    localparam int IDLE_CYC     = MEASURE_CYC;
    localparam int MEMORY_CYC   = 64 * ACCESS_CYC;
    localparam int VOLUME_CYC   = 2 * (2 * ACCESS_CYC + SETTLE_CYC + MEASURE_CYC + 1);
    localparam int MIX_CYC      = 3 * (8 * ACCESS_CYC + SETTLE_CYC + MEASURE_CYC + 1);
    localparam int RELOAD_CYC   = 2 * (4 * RELOAD_LIMIT + 10);
    localparam int WATCHDOG_CYC = IDLE_CYC + MEMORY_CYC + VOLUME_CYC + MIX_CYC
                                  + RELOAD_CYC + 1000;

    logic                           clk;
    logic                           reset_i;
    logic                           host_req_i;
    logic                           host_we_i;
    addr_t                          host_addr_i;
    word_t                          host_wdata_i;
    logic                           host_ack_o;
    word_t                          host_rdata_o;
    logic [NCH-1:0]                 enable_nchan_i;
    logic [7*NCH-1:0]               vol_l_nchan_i;
    logic [7*NCH-1:0]               vol_r_nchan_i;
    logic [15*NCH-1:0]              period_nchan_i;
    logic [`VRAM_W*NCH-1:0]         start_nchan_i;
    logic [15*NCH-1:0]              len_nchan_i;
    logic [NCH-1:0]                 restart_nchan_i;
    logic [NCH-1:0]                 reload_nchan_o;
    logic                           pdm_l_o;
    logic                           pdm_r_o;

    integer seed;
    int     errors;
    int     host_acks;

    // model of what each lane plays
    int     model_byte [NCH];
    int     model_vl   [NCH];
    int     model_vr   [NCH];
    bit     model_en   [NCH];

    audio_subsystem dut_i (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (host_ack_o) begin
            host_acks++;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic host_access(input logic we, input addr_t addr, input word_t wdata,
                               output word_t rdata);
        int waited;
        waited       = 0;
        host_req_i   = 1'b1;
        host_we_i    = we;
        host_addr_i  = addr;
        host_wdata_i = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!host_ack_o && waited < ACK_LIMIT);
        rdata = host_rdata_o;
        assert (host_ack_o) else begin
            $display("host access to address %0h was never acknowledged", addr);
            errors++;
        end
        host_req_i = 1'b0;              // dropped before the next edge
        host_we_i  = 1'b0;
        @(negedge clk);
        assert (!host_ack_o) else begin
            $display("host ack for address %0h stayed high a second cycle", addr);
            errors++;
        end
    endtask

    task automatic host_write(input addr_t addr, input word_t data);
        word_t unused;
        host_access(1'b1, addr, data, unused);
    endtask

    task automatic host_read(input addr_t addr, output word_t data);
        host_access(1'b0, addr, '0, data);
    endtask

    task automatic count_pulses(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (MEASURE_CYC) begin
            @(negedge clk);
            ones_l += int'(pdm_l_o);
            ones_r += int'(pdm_r_o);
        end
    endtask

    // clamp to the DAC range after the shift, then offset to unsigned
    function automatic int expected_level(input bit right);
        int sum;
        int hi;
        int lo;
        bit any;
        sum = 0;
        any = 1'b0;
        for (int i = 0; i < NCH; i++) begin
            if (model_en[i]) begin
                any = 1'b1;
                sum += model_byte[i] * (right ? model_vr[i] : model_vl[i]);
            end
        end
        if (!any) begin
            return 0;                   // silent when nothing plays
        end
        hi = (2 ** (`DAC_W - 1) - 1) * (2 ** `VOL_SHIFT);
        lo = -(2 ** (`DAC_W - 1)) * (2 ** `VOL_SHIFT);
        if (sum > hi) begin
            sum = hi;
        end else if (sum < lo) begin
            sum = lo;
        end
        return (sum >>> `VOL_SHIFT) + 2 ** (`DAC_W - 1);
    endfunction

    task automatic quiet_channels();
        enable_nchan_i = '0;
        for (int i = 0; i < NCH; i++) begin
            model_en[i] = 1'b0;
        end
        @(negedge clk);
    endtask

    task automatic fill_buffer(input int st, input int words, input int smp);
        for (int w = 0; w < words; w++) begin
            host_write(addr_t'(st + w), {2{smp[7:0]}});
        end
    endtask

    // program one lane and start it playing
    task automatic set_channel(input int ch, input int smp, input int vl, input int vr,
                               input int per, input int st, input int ln);
        vol_l_nchan_i[7*ch +: 7]               = 7'(vl);
        vol_r_nchan_i[7*ch +: 7]               = 7'(vr);
        period_nchan_i[15*ch +: 15]            = 15'(per);
        start_nchan_i[`VRAM_W*ch +: `VRAM_W]   = `VRAM_W'(st);
        len_nchan_i[15*ch +: 15]               = 15'(ln);
        enable_nchan_i[ch]                     = 1'b1;
        model_byte[ch] = smp;
        model_vl[ch]   = vl;
        model_vr[ch]   = vr;
        model_en[ch]   = 1'b1;
    endtask

    task automatic setup_lane(input int ch, input int smp, input int vl, input int vr);
        if (ch < NCH) begin
            fill_buffer('h200 + 'h20 * ch, 2, smp);
            set_channel(ch, smp, vl, vr, 30 + 3 * ch, 'h200 + 'h20 * ch, 1);
        end
    endtask

    task automatic play_and_compare(input string name);
        int ones_l;
        int ones_r;
        repeat (SETTLE_CYC) @(negedge clk);
        count_pulses(ones_l, ones_r);
        check_value({name, " left"}, expected_level(1'b0), ones_l);
        check_value({name, " right"}, expected_level(1'b1), ones_r);
    endtask

    task automatic wait_reload(input int ch, output int waited);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!reload_nchan_o[ch] && waited < RELOAD_LIMIT);
        assert (reload_nchan_o[ch]) else begin
            $display("no reload strobe from channel %0d within %0d clocks", ch, RELOAD_LIMIT);
            errors++;
        end
    endtask

    task automatic idle_outputs();
        int ones_l;
        int ones_r;
        int strobes;
        ones_l  = 0;
        ones_r  = 0;
        strobes = 0;
        repeat (MEASURE_CYC) begin
            @(negedge clk);
            ones_l  += int'(pdm_l_o);
            ones_r  += int'(pdm_r_o);
            strobes += int'(reload_nchan_o != '0);
        end
        check_value("idle_outputs left pulses", 0, ones_l);
        check_value("idle_outputs right pulses", 0, ones_r);
        check_value("idle_outputs reload strobes", 0, strobes);
    endtask

    task automatic memory_readback();
        addr_t addrs [16];
        word_t datas [16];
        addr_t a;
        word_t d;
        word_t rd;
        int    acks_before;
        for (int i = 0; i < 16; i++) begin
            addrs[i] = addr_t'(i * 8 + ($random(seed) & 7));   // distinct addresses
            datas[i] = word_t'($random(seed));
            host_write(addrs[i], datas[i]);
        end
        for (int i = 0; i < 16; i++) begin
            host_read(addrs[i], rd);
            check_value("memory_readback", int'(datas[i]), int'(rd));
        end
        // again with two channels fetching at the fastest rate
        set_channel(0, 0, 0, 0, 8, 'h300, 7);
        set_channel(1, 0, 0, 0, 8, 'h340, 3);
        acks_before = host_acks;
        for (int i = 0; i < 16; i++) begin
            a = addr_t'('h100 + i * 4 + ($random(seed) & 3));
            d = word_t'($random(seed));
            host_write(a, d);
            host_read(a, rd);
            check_value("memory_under_fetch", int'(d), int'(rd));
        end
        check_value("memory_under_fetch ack count", 32, host_acks - acks_before);
        quiet_channels();
    endtask

    task automatic single_channel_volume();
        int smp;
        for (int t = 0; t < 2; t++) begin
            quiet_channels();
            smp = int'(sbyte_t'($random(seed)));
            fill_buffer('h200, 2, smp);
            set_channel(0, smp, $random(seed) & 127, $random(seed) & 127, 30, 'h200, 1);
            play_and_compare("single_channel_volume");
        end
    endtask

    task automatic multi_channel_mix();
        quiet_channels();
        setup_lane(0, 40, 30, 90);
        setup_lane(1, -25, 50, 10);
        setup_lane(2, 12, 100, 60);
        setup_lane(3, -7, 20, 127);
        play_and_compare("multi_channel_in_range");
        enable_nchan_i[1] = 1'b0;       // its term drops out of the sum
        model_en[1]       = 1'b0;
        play_and_compare("multi_channel_one_off");
        quiet_channels();
        setup_lane(0, 100, 127, 0);     // left saturates high, right low
        setup_lane(1, 100, 127, 0);
        setup_lane(2, -100, 0, 127);
        setup_lane(3, -100, 0, 127);
        play_and_compare("multi_channel_clamped");
        quiet_channels();
    endtask

    task automatic reload_timing();
        int per [2];
        int ln  [2];
        int waited;
        int interval;
        per[0] = 9;
        ln[0]  = 2;
        per[1] = 15;
        ln[1]  = 4;
        for (int s = 0; s < 2; s++) begin
            quiet_channels();
            set_channel(1, 0, 0, 0, per[s], 'h280, ln[s]);
            interval = 2 * (ln[s] + 1) * (per[s] + 1);
            wait_reload(1, waited);     // first strobe only aligns the count
            repeat (2) begin
                wait_reload(1, waited);
                check_value("reload_interval", interval, waited);
            end
            repeat (5) @(negedge clk);
            restart_nchan_i[1] = 1'b1;
            @(negedge clk);
            restart_nchan_i[1] = 1'b0;
            wait_reload(1, waited);
            assert (waited + 1 <= per[s] + 3) else begin
                $display("[ERROR] reload_restart: expected at most %0d, actual %0d",
                         per[s] + 3, waited + 1);
                errors++;
            end
        end
        quiet_channels();
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d clocks, run stopped", WATCHDOG_CYC);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed            = 32'h07da_14db;
        errors          = 0;
        host_acks       = 0;
        reset_i         = 1'b1;
        host_req_i      = 1'b0;
        host_we_i       = 1'b0;
        host_addr_i     = '0;
        host_wdata_i    = '0;
        enable_nchan_i  = '0;
        vol_l_nchan_i   = '0;
        vol_r_nchan_i   = '0;
        period_nchan_i  = '0;
        start_nchan_i   = '0;
        len_nchan_i     = '0;
        restart_nchan_i = '0;
        for (int i = 0; i < NCH; i++) begin
            model_en[i] = 1'b0;
        end
        repeat (2) @(negedge clk);
        reset_i = 1'b0;

        idle_outputs();
        memory_readback();
        single_channel_volume();
        multi_channel_mix();
        reload_timing();

        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- logic/audio_dac.sv
/*
 * PDM audio DAC
 * First-order sigma-delta, the accumulator carry is the output pulse.
 */

module audio_dac
    import audio_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  dac_t    value_i,
    output logic    pulse_o
);

    dac_t acc;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            {pulse_o, acc} <= {1'b0, acc} + {1'b0, value_i};   // v carries per 256 clocks
        end
    end

endmodule

//--- logic/audio_macros.svh
/*
 * Audio block build-time constants
 * Channel count, VRAM addressing and the mixer/DAC arithmetic widths.
 */

`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// number of sample channels, two or more
`define AUDIO_NCHAN 4

// VRAM word address width
`define VRAM_W 10

// DAC input width, unsigned
`define DAC_W 8

// signed mix accumulator width
`define ACC_W 18

// accumulator right shift to get a DAC_W-bit level
`define VOL_SHIFT 6

`endif

//--- logic/audio_mixer.sv
/*
 * Audio channel mixer
 * Per-channel sample timing and VRAM word fetch, then a time-shared
 * volume multiply-accumulate that yields one clamped level pair per frame.
 */

`include "audio_macros.svh"

module audio_mixer
    import audio_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset_i,

    input  logic [`AUDIO_NCHAN-1:0]             enable_nchan_i,
    input  logic [7*`AUDIO_NCHAN-1:0]           vol_l_nchan_i,
    input  logic [7*`AUDIO_NCHAN-1:0]           vol_r_nchan_i,
    input  logic [15*`AUDIO_NCHAN-1:0]          period_nchan_i,
    input  logic [`VRAM_W*`AUDIO_NCHAN-1:0]     start_nchan_i,
    input  logic [15*`AUDIO_NCHAN-1:0]          len_nchan_i,
    input  logic [`AUDIO_NCHAN-1:0]             restart_nchan_i,
    output logic [`AUDIO_NCHAN-1:0]             reload_nchan_o,

    output logic                                fetch_req_o,
    input  logic                                fetch_ack_i,
    output addr_t                               fetch_addr_o,
    input  word_t                               fetch_word_i,

    output dac_t                                mix_l_o,
    output dac_t                                mix_r_o
);

    localparam int CHAN_W = $clog2(`AUDIO_NCHAN);
    localparam int ACC_HI = (2 ** (`DAC_W - 1) - 1) * (2 ** `VOL_SHIFT);
    localparam int ACC_LO = -(2 ** (`DAC_W - 1)) * (2 ** `VOL_SHIFT);

    logic [15:0]                period_cnt [`AUDIO_NCHAN];  // bit 15 set means sample due
    logic [15:0]                length_cnt [`AUDIO_NCHAN];  // words left, bit 15 forces reload
    addr_t                      chan_addr  [`AUDIO_NCHAN];
    word_t                      chan_buf   [`AUDIO_NCHAN];
    sbyte_t                     chan_val   [`AUDIO_NCHAN];  // byte currently playing
    logic [`AUDIO_NCHAN-1:0]    buf_valid;
    logic [`AUDIO_NCHAN-1:0]    chan_2nd;                   // next byte is the low one

    fetch_phase_t               fetch_phase;
    logic [CHAN_W-1:0]          fetch_chan;
    mix_phase_t                 mix_phase;
    logic [CHAN_W-1:0]          mix_chan;

    sbyte_t                     mix_val;
    sbyte_t                     vol_l;
    sbyte_t                     vol_r;
    sword_t                     prod_l;
    sword_t                     prod_r;
    logic signed [`ACC_W-1:0]   acc_l;
    logic signed [`ACC_W-1:0]   acc_r;

    function automatic logic [CHAN_W-1:0] next_chan(input logic [CHAN_W-1:0] ch);
        return (ch == CHAN_W'(`AUDIO_NCHAN - 1)) ? '0 : ch + 1'b1;
    endfunction

    // clamp, scale down, flip sign bit for an unsigned DAC level
    function automatic dac_t to_dac(input logic signed [`ACC_W-1:0] acc);
        logic signed [`ACC_W-1:0] lim;
        if (acc < ACC_LO) begin
            lim = `ACC_W'(ACC_LO);
        end else if (acc > ACC_HI) begin
            lim = `ACC_W'(ACC_HI);
        end else begin
            lim = acc;
        end
        lim = lim >>> `VOL_SHIFT;
        return {~lim[`DAC_W-1], lim[`DAC_W-2:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_req_o    <= 1'b0;
            fetch_phase    <= FETCH_SETUP;
            fetch_chan     <= '0;
            buf_valid      <= '0;
            chan_2nd       <= '0;
            reload_nchan_o <= '0;
            for (int i = 0; i < `AUDIO_NCHAN; i++) begin
                period_cnt[i] <= 16'h8000;
                length_cnt[i] <= 16'h8000;
                chan_val[i]   <= '0;
            end
        end else begin
            case (fetch_phase)
                FETCH_SETUP: begin
                    if (enable_nchan_i[fetch_chan] && !buf_valid[fetch_chan]) begin
                        fetch_req_o  <= 1'b1;
                        fetch_addr_o <= chan_addr[fetch_chan];
                        fetch_phase  <= FETCH_WAIT;
                    end else begin
                        fetch_chan <= next_chan(fetch_chan);    // nothing to do, move on
                    end
                end
                FETCH_WAIT: begin
                    if (fetch_ack_i) begin
                        fetch_req_o           <= 1'b0;
                        chan_buf[fetch_chan]  <= fetch_word_i;
                        buf_valid[fetch_chan] <= 1'b1;
                        fetch_chan            <= next_chan(fetch_chan);
                        fetch_phase           <= FETCH_SETUP;
                    end
                end
                default: fetch_phase <= FETCH_SETUP;
            endcase

            // channel loop comes after the fetch so a same-cycle clear of buf_valid wins
            for (int i = 0; i < `AUDIO_NCHAN; i++) begin
                reload_nchan_o[i] <= 1'b0;
                period_cnt[i]     <= period_cnt[i] - 1'b1;

                if (enable_nchan_i[i] && period_cnt[i][15]) begin
                    period_cnt[i] <= {1'b0, period_nchan_i[15*i +: 15]} - 16'd1;
                    chan_2nd[i]   <= !chan_2nd[i];
                    if (!chan_2nd[i]) begin
                        chan_val[i] <= buf_valid[i] ? chan_buf[i][15:8] : '0;
                    end else begin
                        // low byte used, word is done
                        chan_val[i]  <= buf_valid[i] ? chan_buf[i][7:0] : '0;
                        buf_valid[i] <= 1'b0;
                        if (length_cnt[i][15] || length_cnt[i][14:0] == '0) begin
                            chan_addr[i]      <= start_nchan_i[`VRAM_W*i +: `VRAM_W];
                            length_cnt[i]     <= {1'b0, len_nchan_i[15*i +: 15]};
                            reload_nchan_o[i] <= 1'b1;
                        end else begin
                            chan_addr[i]  <= chan_addr[i] + 1'b1;
                            length_cnt[i] <= length_cnt[i] - 1'b1;
                        end
                    end
                end

                // next enabled cycle becomes a word end with reload
                if (restart_nchan_i[i] || !enable_nchan_i[i]) begin
                    period_cnt[i][15] <= 1'b1;
                    length_cnt[i][15] <= 1'b1;
                    chan_2nd[i]       <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        prod_l = mix_val * vol_l;
        prod_r = mix_val * vol_r;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_phase <= MIX_MULT;
            mix_chan  <= '0;
            acc_l     <= '0;
            acc_r     <= '0;
            mix_l_o   <= '0;
            mix_r_o   <= '0;
        end else begin
            case (mix_phase)
                MIX_MULT: begin
                    if (mix_chan == '0) begin   // frame boundary
                        if (|enable_nchan_i) begin
                            mix_l_o <= to_dac(acc_l);
                            mix_r_o <= to_dac(acc_r);
                        end else begin
                            mix_l_o <= '0;      // silent when nothing plays
                            mix_r_o <= '0;
                        end
                        acc_l <= '0;
                        acc_r <= '0;
                    end
                    mix_val   <= enable_nchan_i[mix_chan] ? chan_val[mix_chan] : '0;
                    vol_l     <= {1'b0, vol_l_nchan_i[7*mix_chan +: 7]};
                    vol_r     <= {1'b0, vol_r_nchan_i[7*mix_chan +: 7]};
                    mix_phase <= MIX_ACCUM;
                end
                MIX_ACCUM: begin
                    acc_l     <= acc_l + `ACC_W'(prod_l);
                    acc_r     <= acc_r + `ACC_W'(prod_r);
                    mix_chan  <= next_chan(mix_chan);
                    mix_phase <= MIX_MULT;
                end
                default: mix_phase <= MIX_MULT;
            endcase
        end
    end

endmodule

//--- logic/audio_pkg.sv
/*
 * Audio package
 * Word, sample and product types plus the FSM state encodings
 * used by the fetcher, the mixer and the VRAM arbiter.
 */

`include "audio_macros.svh"

package audio_pkg;

    typedef logic [15:0] word_t;                // two samples, high byte plays first
    typedef logic [`VRAM_W-1:0] addr_t;         // VRAM word address
    typedef logic signed [7:0] sbyte_t;         // sample or volume operand
    typedef logic signed [15:0] sword_t;        // sample * volume
    typedef logic [`DAC_W-1:0] dac_t;           // unsigned level into a DAC

    // sample word fetcher
    typedef enum logic {
        FETCH_SETUP,                            // pick channel, raise req
        FETCH_WAIT                              // hold req until ack
    } fetch_phase_t;

    // two cycles per channel in the mixer
    typedef enum logic {
        MIX_MULT,
        MIX_ACCUM
    } mix_phase_t;

    // VRAM arbiter
    typedef enum logic [1:0] {
        GRANT_IDLE,
        GRANT_HOST,
        GRANT_AUDIO
    } grant_t;

endpackage

//--- logic/audio_subsystem.sv
/*
 * Audio subsystem top
 * Sample VRAM shared by host and fetcher, channel mixer, two PDM DACs.
 */

`include "audio_macros.svh"

module audio_subsystem
    import audio_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset_i,

    input  logic                                host_req_i,
    input  logic                                host_we_i,
    input  addr_t                               host_addr_i,
    input  word_t                               host_wdata_i,
    output logic                                host_ack_o,
    output word_t                               host_rdata_o,

    input  logic [`AUDIO_NCHAN-1:0]             enable_nchan_i,
    input  logic [7*`AUDIO_NCHAN-1:0]           vol_l_nchan_i,
    input  logic [7*`AUDIO_NCHAN-1:0]           vol_r_nchan_i,
    input  logic [15*`AUDIO_NCHAN-1:0]          period_nchan_i,
    input  logic [`VRAM_W*`AUDIO_NCHAN-1:0]     start_nchan_i,
    input  logic [15*`AUDIO_NCHAN-1:0]          len_nchan_i,
    input  logic [`AUDIO_NCHAN-1:0]             restart_nchan_i,
    output logic [`AUDIO_NCHAN-1:0]             reload_nchan_o,

    output logic                                pdm_l_o,
    output logic                                pdm_r_o
);

    logic   mem_en;
    logic   mem_we;
    addr_t  mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;
    logic   aud_req;
    logic   aud_ack;
    addr_t  aud_addr;
    word_t  aud_rdata;
    dac_t   mix_l;
    dac_t   mix_r;

    vram vram_i (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    vram_arbiter arbiter_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .host_req_i   (host_req_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_o   (host_ack_o),
        .host_rdata_o (host_rdata_o),
        .aud_req_i    (aud_req),
        .aud_addr_i   (aud_addr),
        .aud_ack_o    (aud_ack),
        .aud_rdata_o  (aud_rdata),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata)
    );

    audio_mixer mixer_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .enable_nchan_i  (enable_nchan_i),
        .vol_l_nchan_i   (vol_l_nchan_i),
        .vol_r_nchan_i   (vol_r_nchan_i),
        .period_nchan_i  (period_nchan_i),
        .start_nchan_i   (start_nchan_i),
        .len_nchan_i     (len_nchan_i),
        .restart_nchan_i (restart_nchan_i),
        .reload_nchan_o  (reload_nchan_o),
        .fetch_req_o     (aud_req),
        .fetch_ack_i     (aud_ack),
        .fetch_addr_o    (aud_addr),
        .fetch_word_i    (aud_rdata),
        .mix_l_o         (mix_l),
        .mix_r_o         (mix_r)
    );

    audio_dac dac_l_i (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (mix_l),
        .pulse_o (pdm_l_o)
    );

    audio_dac dac_r_i (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (mix_r),
        .pulse_o (pdm_r_o)
    );

endmodule

//--- logic/vram.sv
/*
 * Sample VRAM
 * Single-port synchronous word memory, read data one cycle after enable.
 */

`include "audio_macros.svh"

module vram
    import audio_pkg::*;
(
    input  logic    clk,
    input  logic    en_i,
    input  logic    we_i,
    input  addr_t   addr_i,
    input  word_t   wdata_i,
    output word_t   rdata_o
);

    localparam int DEPTH = 2 ** `VRAM_W;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];     // old contents on a write cycle
        end
    end

endmodule

//--- logic/vram_arbiter.sv
/*
 * VRAM arbiter
 * Round-robin sharing of the sample memory between the host port
 * and the audio fetcher, using a hold-req-until-ack handshake.
 */

module vram_arbiter
    import audio_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,

    input  logic    host_req_i,
    input  logic    host_we_i,
    input  addr_t   host_addr_i,
    input  word_t   host_wdata_i,
    output logic    host_ack_o,
    output word_t   host_rdata_o,

    input  logic    aud_req_i,
    input  addr_t   aud_addr_i,
    output logic    aud_ack_o,
    output word_t   aud_rdata_o,

    output logic    mem_en_o,
    output logic    mem_we_o,
    output addr_t   mem_addr_o,
    output word_t   mem_wdata_o,
    input  word_t   mem_rdata_i
);

    grant_t state;
    logic   last_aud;           // audio got the previous grant
    logic   host_pend;
    logic   aud_pend;
    logic   pick_host;

    // a peer seeing its ack still holds req this cycle, so mask it
    assign host_pend = host_req_i && !host_ack_o;
    assign aud_pend  = aud_req_i && !aud_ack_o;
    assign pick_host = host_pend && (!aud_pend || last_aud);

    // memory data is shared, only the ack says whose it is
    assign host_rdata_o = mem_rdata_i;
    assign aud_rdata_o  = mem_rdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= GRANT_IDLE;
            last_aud   <= 1'b0;
            host_ack_o <= 1'b0;
            aud_ack_o  <= 1'b0;
            mem_en_o   <= 1'b0;
            mem_we_o   <= 1'b0;
        end else begin
            mem_en_o   <= 1'b0;
            mem_we_o   <= 1'b0;
            host_ack_o <= 1'b0;
            aud_ack_o  <= 1'b0;

            case (state)
                GRANT_IDLE: begin
                    if (pick_host) begin
                        mem_en_o    <= 1'b1;
                        mem_we_o    <= host_we_i;
                        mem_addr_o  <= host_addr_i;
                        mem_wdata_o <= host_wdata_i;
                        last_aud    <= 1'b0;
                        state       <= GRANT_HOST;
                    end else if (aud_pend) begin
                        mem_en_o    <= 1'b1;
                        mem_addr_o  <= aud_addr_i;
                        last_aud    <= 1'b1;
                        state       <= GRANT_AUDIO;
                    end
                end
                GRANT_HOST: begin       // memory access cycle, ack lands with rdata
                    host_ack_o <= 1'b1;
                    state      <= GRANT_IDLE;
                end
                GRANT_AUDIO: begin
                    aud_ack_o <= 1'b1;
                    state     <= GRANT_IDLE;
                end
                default: state <= GRANT_IDLE;
            endcase
        end
    end

endmodule
